//--- Bender.yml
package:
  name: display_backend

sources:
  - src/disp_pkg.sv
  - src/mode_pkg.sv
  - src/pix_if.sv
  - src/pixel_scanner.sv
  - src/mode_ctrl.sv
  - src/screen_gen.sv
  - src/seg_scanner.sv
  - src/display_mux.sv
  - src/display_top.sv
  - target: simulation
    files:
      - bench/display_tb.sv

//--- bench/display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module display_tb;
    import disp_pkg::*;
    import mode_pkg::*;

    localparam int DIGIT_PERIOD = 4;
    localparam int FULL = WIDTH * HEIGHT;

    // Buttons and level then a pixel burst
    typedef struct packed {
        logic        next;
        logic        enter;
        logic        back;
        logic        rnd;
        logic [3:0]  lvl;
        logic [15:0] burst;
    } row_t;

    logic       clk;
    logic       rst;
    logic       pix_req;
    logic       btn_next;
    logic       btn_enter;
    logic       btn_back;
    logic [3:0] level;
    rgb565_t    oled_data;
    logic       pix_valid;
    logic [3:0] an;
    logic [7:0] seg;
    logic [1:0] mode;

    row_t       rows[$];
    int         cycle_limit = 0;
    int         cycles = 0;
    logic [7:0] lfsr_state = 8'd24;

    // Reference model state
    logic       model_live = 1'b0;
    mode_t      m_mode;
    logic [1:0] m_cursor;
    int         m_x;
    int         m_y;
    int         m_frame;
    int         m_presc;
    int         m_digit;
    logic       req_valid;
    rgb565_t    req_color;
    logic       exp_valid;
    rgb565_t    exp_data;
    logic [3:0] exp_an;
    logic [7:0] exp_seg;

    display_top #(
        .DIGIT_PERIOD (DIGIT_PERIOD)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .pix_req   (pix_req),
        .btn_next  (btn_next),
        .btn_enter (btn_enter),
        .btn_back  (btn_back),
        .level     (level),
        .oled_data (oled_data),
        .pix_valid (pix_valid),
        .an        (an),
        .seg       (seg),
        .mode      (mode)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // One LFSR step per level bit
    task automatic draw_level(output logic [3:0] v);
        v = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[2:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input logic n, input logic e, input logic b, input logic rnd,
                           input logic [3:0] lv, input int len);
        row_t r;
        r.next  = n;
        r.enter = e;
        r.back  = b;
        r.rnd   = rnd;
        r.lvl   = lv;
        r.burst = 16'(len);
        rows.push_back(r);
    endtask

    // Segments lit as gfedcba and inverted for the active-low pins
    function automatic logic [7:0] digit_segments(input int d);
        logic [6:0] on;
        case (d)
            0:       on = 7'h3F;
            1:       on = 7'h06;
            2:       on = 7'h5B;
            3:       on = 7'h4F;
            4:       on = 7'h66;
            5:       on = 7'h6D;
            6:       on = 7'h7D;
            7:       on = 7'h07;
            8:       on = 7'h7F;
            default: on = 7'h6F;
        endcase
        return {1'b1, ~on};
    endfunction

    // Expected {an, seg} for one digit slot
    function automatic logic [11:0] segment_drive(input mode_t md, input logic [1:0] cur,
                                                  input logic [3:0] lv, input int dig);
        if (md == MODE_MENU && dig == 0) begin
            return {4'b1110, digit_segments(cur + 1)};
        end
        if (md == MODE_LEVEL && dig == 0) begin
            return {4'b1110, digit_segments(lv % 10)};
        end
        if (md == MODE_LEVEL && dig == 1) begin
            return {4'b1101, digit_segments(lv / 10)};
        end
        return {AN_OFF, SEG_BLANK};
    endfunction

    // Screen colors per mode
    function automatic rgb565_t paint_pixel(input mode_t md, input logic [1:0] cur,
                                            input logic [3:0] lv, input int x, input int y,
                                            input int fr);
        int band;
        band = (y <= 20) ? 0 : ((y <= 41) ? 1 : 2);
        case (md)
            MODE_MENU:    return (band == cur) ? COLOR_WHITE : COLOR_GREY;
            MODE_LEVEL:   return (x < 6 * lv) ? COLOR_GREEN : COLOR_BLACK;
            MODE_LOADING: return (((x + y + fr) >> 3) & 1) ? COLOR_BLUE : COLOR_BLACK;
            default:      return COLOR_GREEN;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Reads inputs as sampled at the edge
    always @(posedge clk) begin
        if (rst) begin
            model_live = 1'b1;
            m_mode     = MODE_MENU;
            m_cursor   = 2'd0;
            m_x        = 0;
            m_y        = 0;
            m_frame    = 0;
            m_presc    = 0;
            m_digit    = 0;
            req_valid  = 1'b0;
            exp_valid  = 1'b0;
            exp_data   = COLOR_BLACK;
            exp_an     = AN_OFF;
            exp_seg    = SEG_BLANK;
        end else begin
            // Segment register sees the state before this edge
            {exp_an, exp_seg} = segment_drive(m_mode, m_cursor, level, m_digit);
            if (m_presc == DIGIT_PERIOD - 1) begin
                m_presc = 0;
                m_digit = (m_digit + 1) % 4;
            end else begin
                m_presc = m_presc + 1;
            end
            // Buttons with back first
            if (btn_back) begin
                m_mode = MODE_MENU;
            end else if (m_mode == MODE_MENU) begin
                if (btn_enter) begin
                    case (m_cursor)
                        2'd0:    m_mode = MODE_LEVEL;
                        2'd1:    m_mode = MODE_LOADING;
                        default: m_mode = MODE_WIN;
                    endcase
                end else if (btn_next) begin
                    m_cursor = (m_cursor == 2'd2) ? 2'd0 : m_cursor + 2'd1;
                end
            end
            // Two-stage pixel pipe
            exp_valid = req_valid;
            if (req_valid) begin
                exp_data = req_color;
            end
            req_valid = pix_req;
            if (pix_req) begin
                req_color = paint_pixel(m_mode, m_cursor, level, m_x, m_y, m_frame);
                if (m_x == WIDTH - 1) begin
                    m_x = 0;
                    if (m_y == HEIGHT - 1) begin
                        m_y     = 0;
                        m_frame = (m_frame + 1) % 16;
                    end else begin
                        m_y = m_y + 1;
                    end
                end else begin
                    m_x = m_x + 1;
                end
            end
        end
    end

    // Outputs compared mid-cycle
    always @(negedge clk) begin
        if (model_live) begin
            compare_value("pix_valid", pix_valid, exp_valid);
            compare_value("oled_data", oled_data, exp_data);
            compare_value("an", an, exp_an);
            compare_value("seg", seg, exp_seg);
            compare_value("mode", mode, m_mode);
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run still busy after %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "Run aborted by the cycle limit");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        int         total;
        logic [3:0] lv;
        row_t       row;
        clk       = 1'b0;
        rst       = 1'b1;
        pix_req   = 1'b0;
        btn_next  = 1'b0;
        btn_enter = 1'b0;
        btn_back  = 1'b0;
        level     = 4'd0;

        // next, enter, back, random level, level, burst
        add_row(0, 0, 0, 0, 0, FULL);
        add_row(1, 0, 0, 0, 0, FULL);
        add_row(1, 0, 0, 0, 0, FULL);
        add_row(1, 0, 0, 0, 0, 200);
        // Level bar
        add_row(0, 1, 0, 1, 0, FULL);
        add_row(0, 0, 0, 1, 0, 300);
        add_row(0, 0, 0, 1, 0, 300);
        add_row(0, 0, 0, 0, 15, 300);
        // Back to the menu then loading for two frames
        add_row(0, 0, 1, 0, 0, 100);
        add_row(1, 0, 0, 0, 0, 100);
        add_row(0, 1, 0, 0, 0, FULL);
        add_row(0, 0, 0, 0, 0, FULL);
        // Win ignores next until back arrives with enter
        add_row(0, 0, 1, 0, 0, 50);
        add_row(1, 0, 0, 0, 0, 50);
        add_row(0, 1, 0, 0, 0, 500);
        add_row(1, 0, 0, 0, 0, 500);
        add_row(0, 1, 1, 0, 0, 200);
        // Back beats enter and next inside the menu
        add_row(0, 1, 1, 0, 0, 200);
        add_row(1, 0, 1, 0, 0, 100);

        total = 0;
        foreach (rows[i]) begin
            total += rows[i].burst;
        end
        cycle_limit = total + total / 10;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // Idle with no pixel expected
        repeat (6) @(posedge clk);

        for (int r = 0; r < rows.size(); r++) begin
            row = rows[r];
            lv  = row.lvl;
            if (row.rnd) begin
                draw_level(lv);
            end
            btn_next  <= row.next;
            btn_enter <= row.enter;
            btn_back  <= row.back;
            level     <= lv;
            @(posedge clk);
            btn_next  <= 1'b0;
            btn_enter <= 1'b0;
            btn_back  <= 1'b0;
            // Back-to-back requests
            for (int i = 0; i < row.burst; i++) begin
                pix_req <= 1'b1;
                @(posedge clk);
            end
            pix_req <= 1'b0;
            // Drain the two in flight
            repeat (3) @(posedge clk);
        end

        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/disp_pkg.sv
src/mode_pkg.sv
src/pix_if.sv
src/pixel_scanner.sv
src/mode_ctrl.sv
src/screen_gen.sv
src/seg_scanner.sv
src/display_mux.sv
src/display_top.sv
bench/display_tb.sv

//--- src/disp_pkg.sv
`default_nettype none

package disp_pkg;

    //////////////////////////////
    // Panel geometry
    //////////////////////////////
    parameter int WIDTH  = 96;
    parameter int HEIGHT = 64;

    typedef logic [6:0] coord_x_t;
    typedef logic [5:0] coord_y_t;

    // RGB565, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    //////////////////////////////
    // Fixed colors
    //////////////////////////////
    parameter rgb565_t COLOR_BLACK = 16'h0000;
    parameter rgb565_t COLOR_WHITE = 16'hFFFF;
    parameter rgb565_t COLOR_GREY  = 16'h8410;
    parameter rgb565_t COLOR_GREEN = 16'h07E0;
    parameter rgb565_t COLOR_BLUE  = 16'h001F;

    // Seven-segment idle drive, both active low
    parameter logic [7:0] SEG_BLANK = 8'hFF;
    parameter logic [3:0] AN_OFF    = 4'hF;

endpackage

`default_nettype wire

//--- src/display_mux.sv
`timescale 1ns/1ps
`default_nettype none

module display_mux (
    input  logic              clk,
    input  logic              rst,
    input  mode_pkg::mode_t   mode,
    pix_if.sink               pix,
    input  disp_pkg::rgb565_t color,
    input  logic [3:0]        an_raw,
    input  logic [7:0]        seg_raw,
    output disp_pkg::rgb565_t oled_data,
    output logic              pix_valid,
    output logic [3:0]        an,
    output logic [7:0]        seg
);
    import disp_pkg::*;
    import mode_pkg::*;

    //////////////////////////////
    // Pixel register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            oled_data <= COLOR_BLACK;
        end else begin
            pix_valid <= pix.strobe;
            // Last pixel held between strobes
            if (pix.strobe) begin
                oled_data <= color;
            end
        end
    end

    //////////////////////////////
    // Segment register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            an  <= AN_OFF;
            seg <= SEG_BLANK;
        end else begin
            case (mode)
                MODE_MENU, MODE_LEVEL: begin
                    an  <= an_raw;
                    seg <= seg_raw;
                end
                // No number on the other screens
                default: begin
                    an  <= AN_OFF;
                    seg <= SEG_BLANK;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/display_top.sv
`timescale 1ns/1ps
`default_nettype none

module display_top #(
    parameter int DIGIT_PERIOD = 1024
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pix_req,
    input  logic              btn_next,
    input  logic              btn_enter,
    input  logic              btn_back,
    input  logic [3:0]        level,
    output disp_pkg::rgb565_t oled_data,
    output logic              pix_valid,
    output logic [3:0]        an,
    output logic [7:0]        seg,
    output logic [1:0]        mode
);
    import disp_pkg::*;
    import mode_pkg::*;

    mode_t      mode_s;
    cursor_t    cursor_s;
    rgb565_t    color_s;
    logic [3:0] an_raw_s;
    logic [7:0] seg_raw_s;

    pix_if pix ();

    // Mode seen outside as a plain vector
    assign mode = mode_s;

    //////////////////////////////
    // Pixel path
    //////////////////////////////
    pixel_scanner u_scanner (
        .clk     (clk),
        .rst     (rst),
        .pix_req (pix_req),
        .pix     (pix.src)
    );

    screen_gen u_gen (
        .pix    (pix.sink),
        .mode   (mode_s),
        .cursor (cursor_s),
        .level  (level),
        .color  (color_s)
    );

    //////////////////////////////
    // Control and segments
    //////////////////////////////
    mode_ctrl u_mode (
        .clk       (clk),
        .rst       (rst),
        .btn_next  (btn_next),
        .btn_enter (btn_enter),
        .btn_back  (btn_back),
        .mode      (mode_s),
        .cursor    (cursor_s)
    );

    seg_scanner #(
        .DIGIT_PERIOD (DIGIT_PERIOD)
    ) u_seg (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode_s),
        .cursor  (cursor_s),
        .level   (level),
        .an_raw  (an_raw_s),
        .seg_raw (seg_raw_s)
    );

    // Output registers
    display_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode_s),
        .pix       (pix.sink),
        .color     (color_s),
        .an_raw    (an_raw_s),
        .seg_raw   (seg_raw_s),
        .oled_data (oled_data),
        .pix_valid (pix_valid),
        .an        (an),
        .seg       (seg)
    );

endmodule

`default_nettype wire

//--- src/mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mode_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              btn_next,
    input  logic              btn_enter,
    input  logic              btn_back,
    output mode_pkg::mode_t   mode,
    output mode_pkg::cursor_t cursor
);
    import mode_pkg::*;

    //////////////////////////////
    // Mode FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            mode   <= MODE_MENU;
            cursor <= '0;
        end else if (btn_back) begin
            // Back wins over everything, cursor kept
            mode <= MODE_MENU;
        end else if (mode == MODE_MENU) begin
            if (btn_enter) begin
                case (cursor)
                    2'd0:    mode <= MODE_LEVEL;
                    2'd1:    mode <= MODE_LOADING;
                    2'd2:    mode <= MODE_WIN;
                    default: mode <= MODE_MENU;
                endcase
            end else if (btn_next) begin
                // Wrap after the last entry
                if (cursor == CURSOR_LAST) begin
                    cursor <= '0;
                end else begin
                    cursor <= cursor + 2'd1;
                end
            end
        end
        // Inside a screen only back has an effect
    end

endmodule

`default_nettype wire

//--- src/mode_pkg.sv
`default_nettype none

package mode_pkg;

    // Screen modes, encoding seen on the mode port
    typedef enum logic [1:0] {
        MODE_MENU    = 2'd0,
        MODE_LEVEL   = 2'd1,
        MODE_LOADING = 2'd2,
        MODE_WIN     = 2'd3
    } mode_t;

    // Menu entry index
    // 0 level, 1 loading, 2 win
    typedef logic [1:0] cursor_t;

    parameter cursor_t CURSOR_LAST = 2'd2;

endpackage

`default_nettype wire

//--- src/pix_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pix_if;
    import disp_pkg::*;

    // One-cycle coordinate strobe
    logic     strobe;
    coord_x_t x;
    coord_y_t y;
    // Frame count, animation phase
    logic [3:0] frame;

    // Scanner side
    modport src (output strobe, output x, output y, output frame);

    // Painter and output register side
    modport sink (input strobe, input x, input y, input frame);

endinterface

`default_nettype wire

//--- src/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner (
    input  logic clk,
    input  logic rst,
    input  logic pix_req,
    pix_if.src   pix
);
    import disp_pkg::*;

    coord_x_t   x_cnt;
    coord_y_t   y_cnt;
    logic [3:0] frame_cnt;

    //////////////////////////////
    // Raster counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            x_cnt     <= '0;
            y_cnt     <= '0;
            frame_cnt <= '0;
        end else if (pix_req) begin
            if (x_cnt == coord_x_t'(WIDTH - 1)) begin
                x_cnt <= '0;
                // End of row
                if (y_cnt == coord_y_t'(HEIGHT - 1)) begin
                    y_cnt     <= '0;
                    frame_cnt <= frame_cnt + 4'd1;
                end else begin
                    y_cnt <= y_cnt + 6'd1;
                end
            end else begin
                x_cnt <= x_cnt + 7'd1;
            end
        end
    end

    // Strobe one cycle behind the request
    always_ff @(posedge clk) begin
        if (rst) begin
            pix.strobe <= 1'b0;
        end else begin
            pix.strobe <= pix_req;
        end
    end

    // Coordinate of this request, valid with the strobe only
    always_ff @(posedge clk) begin
        if (pix_req) begin
            pix.x     <= x_cnt;
            pix.y     <= y_cnt;
            pix.frame <= frame_cnt;
        end
    end

endmodule

`default_nettype wire

//--- src/screen_gen.sv
`timescale 1ns/1ps
`default_nettype none

module screen_gen (
    pix_if.sink               pix,
    input  mode_pkg::mode_t   mode,
    input  mode_pkg::cursor_t cursor,
    input  logic [3:0]        level,
    output disp_pkg::rgb565_t color
);
    import disp_pkg::*;
    import mode_pkg::*;

    // Rows per menu band, last band takes the remainder
    localparam int BAND_H = HEIGHT / 3;

    cursor_t    band;
    rgb565_t    menu_color;
    logic [6:0] bar_len;
    rgb565_t    level_color;
    logic [7:0] stripe_sum;
    rgb565_t    loading_color;

    //////////////////////////////
    // Menu
    //////////////////////////////
    always_comb begin
        if (pix.y < coord_y_t'(BAND_H)) begin
            band = 2'd0;
        end else if (pix.y < coord_y_t'(2 * BAND_H)) begin
            band = 2'd1;
        end else begin
            band = 2'd2;
        end
    end

    // Selected entry highlighted
    assign menu_color = (band == cursor) ? COLOR_WHITE : COLOR_GREY;

    //////////////////////////////
    // Level bar
    //////////////////////////////
    // 6 columns per step, 90 at full scale
    assign bar_len     = 7'(level) * 7'd6;
    assign level_color = (pix.x < bar_len) ? COLOR_GREEN : COLOR_BLACK;

    //////////////////////////////
    // Loading stripes
    //////////////////////////////
    // Diagonal stripes, 8 wide, shifted by the frame count
    assign stripe_sum    = 8'(pix.x) + 8'(pix.y) + 8'(pix.frame);
    assign loading_color = stripe_sum[3] ? COLOR_BLUE : COLOR_BLACK;

    // Screen select
    always_comb begin
        case (mode)
            MODE_MENU:    color = menu_color;
            MODE_LEVEL:   color = level_color;
            MODE_LOADING: color = loading_color;
            MODE_WIN:     color = COLOR_GREEN;
            default:      color = COLOR_BLACK;
        endcase
    end

endmodule

`default_nettype wire

//--- src/seg_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module seg_scanner #(
    parameter int DIGIT_PERIOD = 1024
) (
    input  logic              clk,
    input  logic              rst,
    input  mode_pkg::mode_t   mode,
    input  mode_pkg::cursor_t cursor,
    input  logic [3:0]        level,
    output logic [3:0]        an_raw,
    output logic [7:0]        seg_raw
);
    import disp_pkg::*;
    import mode_pkg::*;

    localparam int CNT_W = (DIGIT_PERIOD > 1) ? $clog2(DIGIT_PERIOD) : 1;

    logic [CNT_W-1:0] presc;
    logic [1:0]       digit;
    logic             lit;
    logic [3:0]       value;

    // Active-low gfedcba, decimal point off
    function automatic logic [7:0] seg_encode(input logic [3:0] d);
        case (d)
            4'd0:    return 8'hC0;
            4'd1:    return 8'hF9;
            4'd2:    return 8'hA4;
            4'd3:    return 8'hB0;
            4'd4:    return 8'h99;
            4'd5:    return 8'h92;
            4'd6:    return 8'h82;
            4'd7:    return 8'hF8;
            4'd8:    return 8'h80;
            4'd9:    return 8'h90;
            default: return SEG_BLANK;
        endcase
    endfunction

    //////////////////////////////
    // Digit rotation
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
            digit <= '0;
        end else if (presc == CNT_W'(DIGIT_PERIOD - 1)) begin
            presc <= '0;
            digit <= digit + 2'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // What the current digit shows
    always_comb begin
        lit   = 1'b0;
        value = '0;
        case (mode)
            MODE_MENU: begin
                // Entry number counted from 1
                lit   = (digit == 2'd0);
                value = 4'({2'b00, cursor} + 4'd1);
            end
            MODE_LEVEL: begin
                lit   = (digit == 2'd0) || (digit == 2'd1);
                value = (digit == 2'd0) ? 4'(level % 4'd10) : 4'(level / 4'd10);
            end
            default: begin
                lit = 1'b0;
            end
        endcase
    end

    assign an_raw  = lit ? ~(4'b0001 << digit) : AN_OFF;
    assign seg_raw = lit ? seg_encode(value) : SEG_BLANK;

endmodule

`default_nettype wire
